// File: list.f
+incdir+hw
hw/dmc_pkg.sv
hw/dlm_req_decode.sv
hw/dlm_bank_mem.sv
hw/dlm_load_align.sv
hw/dmc.sv
verification/dmc_assert.sv
verification/tb_dmc.sv

// File: verification/tb_dmc.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module tb_dmc;
   import dmc_pkg::*;

   localparam int    DLM_BYTES = `DMC_DLM_BYTES;
   localparam xlen_t DLM_BASE  = `DMC_DLM_BASE;

   logic     clk, arst_n, ls_val, ls_rdy, ls_is_ld, ls_is_signed, ls_is_external;
   ls_size_e ls_size, ld_size, mst_rif_size, mst_rif_rdata_size, eld_size;
   xlen_t    ls_addr, ls_wdata, ld_data, mst_rif_addr, mst_rif_wdata, mst_rif_rdata, eld_data;
   rd_t      ls_res_rd, ld_rd, mst_rif_rd, mst_rif_rdata_rd, eld_rd;
   logic     ld_val, ld_is_signed, mst_rif_val, mst_rif_rdy, mst_rif_we, mst_rif_signed;
   logic     mst_rif_rdata_val, mst_rif_rdata_rdy, mst_rif_rdata_signed;
   logic     eld_val, eld_rdy, eld_is_signed;

   // Byte model of the DLM and outstanding loads
   logic [7:0] dlm_model [0:DLM_BYTES-1];
   int         cyc;
   int         exp_cyc[$];
   xlen_t      exp_data[$];
   ls_size_e   exp_size[$];
   logic       exp_signed[$];
   rd_t        exp_rd[$];

   dmc dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------
   // Reporting and compares
   // ------------------------------

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp) abort_run($sformatf("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp));
   endtask

   task automatic check_size(input string name, input ls_size_e got, input ls_size_e exp);
      if (got !== exp) abort_run($sformatf("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
   endtask

   task automatic check_rd(input string name, input rd_t got, input rd_t exp);
      if (got !== exp) abort_run($sformatf("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) abort_run($sformatf("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp));
   endtask

   function automatic int size_bytes(input ls_size_e s);
      return (s == SIZE_B) ? 1 : (s == SIZE_H) ? 2 : 4;
   endfunction

   // Bytes from the start offset upward with wrap at the DLM top
   function automatic xlen_t model_read(input int off, input int n);
      xlen_t w;
      w = '0;
      for (int k = 0; k < n; k++) begin
         w[k*8 +: 8] = dlm_model[(off + k) % DLM_BYTES];
      end
      return w;
   endfunction

   // ------------------------------
   // Cycle stepping and bus responder
   // ------------------------------

   // Step to the falling edge and check the registered load port
   task automatic next_cycle();
      xlen_t mask;
      @(negedge clk);
      cyc++;
      if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
         check_bit("ld_val", ld_val, 1'b1);
         mask = (size_bytes(exp_size[0]) == 4) ? '1 : (1 << (8 * size_bytes(exp_size[0]))) - 1;
         check_word("ld_data", ld_data & mask, exp_data[0] & mask);
         check_size("ld_size", ld_size, exp_size[0]);
         check_bit("ld_is_signed", ld_is_signed, exp_signed[0]);
         check_rd("ld_rd", ld_rd, exp_rd[0]);
         void'(exp_cyc.pop_front());
         void'(exp_data.pop_front());
         void'(exp_size.pop_front());
         void'(exp_signed.pop_front());
         void'(exp_rd.pop_front());
      end else begin
         // No DLM load due, so the result port stays quiet
         check_bit("ld_val", ld_val, 1'b0);
      end
      // New random responder values each cycle
      mst_rif_rdy          = 1'($urandom % 2);
      mst_rif_rdata_val    = 1'($urandom % 2);
      mst_rif_rdata        = $urandom;
      mst_rif_rdata_size   = ls_size_e'($urandom % 3);
      mst_rif_rdata_signed = 1'($urandom % 2);
      mst_rif_rdata_rd     = rd_t'($urandom);
      eld_rdy              = 1'($urandom % 2);
   endtask

   // Let combinational outputs settle before checking the response echo
   task automatic settle();
      #1;
      check_bit("eld_val", eld_val, mst_rif_rdata_val);
      check_word("eld_data", eld_data, mst_rif_rdata);
      check_size("eld_size", eld_size, mst_rif_rdata_size);
      check_bit("eld_is_signed", eld_is_signed, mst_rif_rdata_signed);
      check_rd("eld_rd", eld_rd, mst_rif_rdata_rd);
      check_bit("mst_rif_rdata_rdy", mst_rif_rdata_rdy, eld_rdy);
   endtask

   task automatic idle();
      next_cycle();
      ls_val = 1'b0;
      settle();
      check_bit("mst_rif_val", mst_rif_val, 1'b0);
   endtask

   // ------------------------------
   // Requests
   // ------------------------------

   task automatic dlm_op(input logic is_ld, input ls_size_e size, input int off);
      xlen_t wdata;
      int    n;
      wdata = $urandom;
      n = size_bytes(size);
      next_cycle();
      ls_val       = 1'b1;
      ls_is_ld     = is_ld;
      ls_size      = size;
      ls_is_signed = 1'($urandom % 2);
      ls_addr      = DLM_BASE + xlen_t'(off);
      ls_wdata     = wdata;
      ls_res_rd    = rd_t'($urandom);
      settle();
      check_bit("ls_rdy", ls_rdy, 1'b1);
      check_bit("ls_is_external", ls_is_external, 1'b0);
      check_bit("mst_rif_val", mst_rif_val, 1'b0);
      if (is_ld) begin
         // Result due two cycles after acceptance
         exp_cyc.push_back(cyc + 2);
         exp_data.push_back(model_read(off, n));
         exp_size.push_back(size);
         exp_signed.push_back(ls_is_signed);
         exp_rd.push_back(ls_res_rd);
      end else begin
         for (int k = 0; k < n; k++) begin
            dlm_model[(off + k) % DLM_BYTES] = wdata[k*8 +: 8];
         end
      end
   endtask

   // Request held with fields unchanged until the bus takes it
   task automatic ext_op();
      xlen_t a;
      logic  done;
      int    t;
      do a = $urandom; while (a - DLM_BASE < xlen_t'(DLM_BYTES));
      next_cycle();
      ls_val       = 1'b1;
      ls_is_ld     = 1'($urandom % 2);
      ls_size      = ls_size_e'($urandom % 3);
      ls_is_signed = 1'($urandom % 2);
      ls_addr      = a;
      ls_wdata     = $urandom;
      ls_res_rd    = rd_t'($urandom);
      done = 1'b0;
      t = 0;
      while (!done && t < 64) begin
         settle();
         check_bit("mst_rif_val", mst_rif_val, 1'b1);
         check_bit("ls_rdy", ls_rdy, mst_rif_rdy);
         check_bit("ls_is_external", ls_is_external, 1'b1);
         check_word("mst_rif_addr", mst_rif_addr, a);
         check_word("mst_rif_wdata", mst_rif_wdata, ls_wdata);
         check_bit("mst_rif_we", mst_rif_we, ~ls_is_ld);
         check_size("mst_rif_size", mst_rif_size, ls_size);
         check_bit("mst_rif_signed", mst_rif_signed, ls_is_signed);
         check_rd("mst_rif_rd", mst_rif_rd, ls_res_rd);
         if (mst_rif_rdy) begin
            done = 1'b1;
         end else begin
            next_cycle();
            t++;
         end
      end
      if (!done) abort_run("timeout waiting for mst_rif_rdy on an external request");
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      int t;
      void'($urandom(32'h33264829));
      arst_n = 1'b0;
      ls_val = 1'b0;
      ls_is_ld = 1'b0;
      ls_size = SIZE_W;
      ls_is_signed = 1'b0;
      ls_addr = '0;
      ls_wdata = '0;
      ls_res_rd = '0;
      mst_rif_rdy = 1'b0;
      mst_rif_rdata_val = 1'b0;
      mst_rif_rdata = '0;
      mst_rif_rdata_size = SIZE_B;
      mst_rif_rdata_signed = 1'b0;
      mst_rif_rdata_rd = '0;
      eld_rdy = 1'b0;
      cyc = 0;
      repeat (16) @(negedge clk);
      arst_n = 1'b1;

      // Quiet port after reset
      repeat (4) idle();

      // Fill every DLM word so no load sees unknown data
      for (int off = 0; off < DLM_BYTES; off += 4) dlm_op(1'b0, SIZE_W, off);

      // Aligned sizes
      dlm_op(1'b0, SIZE_W, 'h40);
      dlm_op(1'b1, SIZE_W, 'h40);
      dlm_op(1'b0, SIZE_H, 'h46);
      dlm_op(1'b1, SIZE_H, 'h46);
      dlm_op(1'b0, SIZE_B, 'h49);
      dlm_op(1'b1, SIZE_B, 'h49);

      // Crossings from bank 0 to 1, from bank 1 into the next row and past the top
      dlm_op(1'b0, SIZE_H, 3);
      dlm_op(1'b1, SIZE_H, 3);
      dlm_op(1'b0, SIZE_W, 6);
      dlm_op(1'b1, SIZE_W, 6);
      dlm_op(1'b0, SIZE_H, 7);
      dlm_op(1'b1, SIZE_H, 7);
      dlm_op(1'b0, SIZE_W, 'hFFE);
      dlm_op(1'b1, SIZE_W, 'hFFE);

      // Back-to-back loads
      for (int k = 0; k < 6; k++) dlm_op(1'b1, SIZE_W, 'h100 + 5 * k);

      // Random mix
      for (int i = 0; i < 800; i++) begin
         int pick;
         pick = $urandom % 10;
         if (pick < 4) dlm_op(1'b1, ls_size_e'($urandom % 3), $urandom % DLM_BYTES);
         else if (pick < 8) dlm_op(1'b0, ls_size_e'($urandom % 3), $urandom % DLM_BYTES);
         else if (pick < 9) ext_op();
         else idle();
      end

      // Drain outstanding loads
      t = 0;
      while (exp_cyc.size() != 0) begin
         if (t == 10) abort_run("timeout waiting for outstanding DLM loads");
         idle();
         t++;
      end
      repeat (2) idle();

      if (dut.chk.fail_cnt == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         abort_run("concurrent assertions reported failures");
      end
   end

endmodule

// File: verification/dmc_assert.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module dmc_assert (
   input logic              clk,
   input logic              arst_n,
   input logic              ls_val,
   input dmc_pkg::ls_size_e ls_size,
   input dmc_pkg::xlen_t    ls_addr,
   input logic              lo_ld_acc,
   input logic              ld_val,
   input logic              mst_rif_val,
   input logic              bank_cs_0,
   input logic              bank_cs_1
);
   import dmc_pkg::*;

   // DLM region bounds with exclusive end
   localparam xlen_t DLM_LO = `DMC_DLM_BASE;
   localparam xlen_t DLM_HI = `DMC_DLM_BASE + `DMC_DLM_BYTES;

   int         fail_cnt = 0;
   logic       dlm_addr;
   logic [2:0] last_lane;
   logic       misaligned;

   // Start byte inside the DLM region
   assign dlm_addr = (ls_addr >= DLM_LO) && (ls_addr < DLM_HI);

   // Last byte lane touched
   // Anything past lane 3 runs into the next word
   // Word-aligned DLM base makes the low address bits the offset
   always_comb begin
      case (ls_size)
         SIZE_B:  last_lane = {1'b0, ls_addr[1:0]};
         SIZE_H:  last_lane = {1'b0, ls_addr[1:0]} + 3'd1;
         default: last_lane = {1'b0, ls_addr[1:0]} + 3'd3;
      endcase
      misaligned = last_lane > 3'd3;
   end

   // ------------------------------
   // Load pipeline latency
   // ------------------------------

   a_ld_latency: assert property (@(posedge clk) disable iff (!arst_n)
      ld_val == $past(lo_ld_acc, 2))
      else begin
         $error("ld_val does not follow a DLM load acceptance by two cycles");
         fail_cnt++;
      end

   // ------------------------------
   // Routing
   // ------------------------------

   a_no_ext_for_dlm: assert property (@(posedge clk) disable iff (!arst_n)
      (ls_val && dlm_addr) |-> !mst_rif_val)
      else begin
         $error("external request raised for a DLM address");
         fail_cnt++;
      end

   a_split_banks: assert property (@(posedge clk) disable iff (!arst_n)
      (ls_val && dlm_addr && misaligned) |-> (bank_cs_0 && bank_cs_1))
      else begin
         $error("misaligned DLM access did not select both banks");
         fail_cnt++;
      end

endmodule

bind dmc dmc_assert chk (
   .clk            (clk),
   .arst_n         (arst_n),
   .ls_val         (ls_val),
   .ls_size        (ls_size),
   .ls_addr        (ls_addr),
   .lo_ld_acc      (lo_ld_acc),
   .ld_val         (ld_val),
   .mst_rif_val    (mst_rif_val),
   .bank_cs_0      (bank_cs[0]),
   .bank_cs_1      (bank_cs[1])
);

// File: hw/dmc.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module dmc (
   input  logic              clk,
   input  logic              arst_n,

   // Core load/store request
   input  logic              ls_val,
   output logic              ls_rdy,
   input  logic              ls_is_ld,
   input  dmc_pkg::ls_size_e ls_size,
   input  logic              ls_is_signed,
   input  dmc_pkg::xlen_t    ls_addr,
   input  dmc_pkg::xlen_t    ls_wdata,
   input  dmc_pkg::rd_t      ls_res_rd,
   output logic              ls_is_external,

   // DLM load result, no back-pressure
   output logic              ld_val,
   output dmc_pkg::xlen_t    ld_data,
   output dmc_pkg::ls_size_e ld_size,
   output logic              ld_is_signed,
   output dmc_pkg::rd_t      ld_rd,

   // External request channel
   output logic              mst_rif_val,
   input  logic              mst_rif_rdy,
   output dmc_pkg::xlen_t    mst_rif_addr,
   output dmc_pkg::xlen_t    mst_rif_wdata,
   output logic              mst_rif_we,
   output dmc_pkg::ls_size_e mst_rif_size,
   output logic              mst_rif_signed,
   output dmc_pkg::rd_t      mst_rif_rd,

   // External read response channel
   input  logic              mst_rif_rdata_val,
   output logic              mst_rif_rdata_rdy,
   input  dmc_pkg::xlen_t    mst_rif_rdata,
   input  dmc_pkg::ls_size_e mst_rif_rdata_size,
   input  logic              mst_rif_rdata_signed,
   input  dmc_pkg::rd_t      mst_rif_rdata_rd,

   // External load result to core
   output logic              eld_val,
   input  logic              eld_rdy,
   output dmc_pkg::xlen_t    eld_data,
   output dmc_pkg::ls_size_e eld_size,
   output logic              eld_is_signed,
   output dmc_pkg::rd_t      eld_rd
);
   import dmc_pkg::*;

   logic       is_external;
   logic       lo_ld_acc;
   logic       bank_cs    [0:`DMC_NBANKS-1];
   logic       bank_we    [0:`DMC_NBANKS-1];
   bank_addr_t bank_row   [0:`DMC_NBANKS-1];
   bank_be_t   bank_be    [0:`DMC_NBANKS-1];
   xlen_t      bank_wdata;
   xlen_t      bank_rdata [0:`DMC_NBANKS-1];

   // ------------------------------
   // Address stage
   // ------------------------------

   dlm_req_decode u_decode (
      .ls_val      (ls_val),
      .ls_is_ld    (ls_is_ld),
      .ls_size     (ls_size),
      .ls_addr     (ls_addr),
      .ls_wdata    (ls_wdata),
      .mst_rif_rdy (mst_rif_rdy),
      .is_external (is_external),
      .lo_ld_acc   (lo_ld_acc),
      .bank_cs     (bank_cs),
      .bank_we     (bank_we),
      .bank_row    (bank_row),
      .bank_be     (bank_be),
      .bank_wdata  (bank_wdata)
   );

   // DLM never stalls
   assign ls_rdy         = ~is_external | mst_rif_rdy;
   assign ls_is_external = is_external;

   // Even/odd word banks, same rotated store data to both
   for (genvar b = 0; b < `DMC_NBANKS; b++) begin : g_bank
      dlm_bank_mem u_bank (
         .clk   (clk),
         .cs    (bank_cs[b]),
         .we    (bank_we[b]),
         .be    (bank_be[b]),
         .row   (bank_row[b]),
         .wdata (bank_wdata),
         .rdata (bank_rdata[b])
      );
   end

   // ------------------------------
   // Data and output stages
   // ------------------------------

   dlm_load_align u_align (
      .clk          (clk),
      .arst_n       (arst_n),
      .lo_ld_acc    (lo_ld_acc),
      .ls_addr      (ls_addr),
      .ls_size      (ls_size),
      .ls_is_signed (ls_is_signed),
      .ls_res_rd    (ls_res_rd),
      .bank_rdata   (bank_rdata),
      .ld_val       (ld_val),
      .ld_data      (ld_data),
      .ld_size      (ld_size),
      .ld_is_signed (ld_is_signed),
      .ld_rd        (ld_rd)
   );

   // ------------------------------
   // External pass-through
   // ------------------------------

   // Request fields go out unchanged
   assign mst_rif_val    = ls_val & is_external;
   assign mst_rif_addr   = ls_addr;
   assign mst_rif_wdata  = ls_wdata;
   assign mst_rif_we     = ~ls_is_ld;
   assign mst_rif_size   = ls_size;
   assign mst_rif_signed = ls_is_signed;
   assign mst_rif_rd     = ls_res_rd;

   // Response straight back to the core
   assign eld_val           = mst_rif_rdata_val;
   assign mst_rif_rdata_rdy = eld_rdy;
   assign eld_data          = mst_rif_rdata;
   assign eld_size          = mst_rif_rdata_size;
   assign eld_is_signed     = mst_rif_rdata_signed;
   assign eld_rd            = mst_rif_rdata_rd;

endmodule

// File: hw/dlm_load_align.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module dlm_load_align (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              lo_ld_acc,
   input  dmc_pkg::xlen_t    ls_addr,
   input  dmc_pkg::ls_size_e ls_size,
   input  logic              ls_is_signed,
   input  dmc_pkg::rd_t      ls_res_rd,
   input  dmc_pkg::xlen_t    bank_rdata [0:`DMC_NBANKS-1],
   output logic              ld_val,
   output dmc_pkg::xlen_t    ld_data,
   output dmc_pkg::ls_size_e ld_size,
   output logic              ld_is_signed,
   output dmc_pkg::rd_t      ld_rd
);
   import dmc_pkg::*;

   localparam int    BYTE_W   = `DMC_XLEN / 8;
   localparam int    OFF_W    = $clog2(BYTE_W);
   localparam int    ROW_LSB  = OFF_W + $clog2(`DMC_NBANKS);
   localparam xlen_t DLM_BASE = `DMC_DLM_BASE;

   logic [ROW_LSB-1:0]  addr_lo;
   logic                val_md;
   logic [OFF_W-1:0]    off_md;
   logic                bsel_md;
   ls_size_e            size_md;
   logic                signed_md;
   rd_t                 rd_md;
   logic [2*BYTE_W-1:0] span_md;
   bank_be_t            be0_md;
   xlen_t               word_out [0:`DMC_NBANKS-1];
   bank_be_t            be0_out;
   logic [OFF_W-1:0]    off_out;
   xlen_t               merged;

   // Offset bits relative to DLM base
   assign addr_lo = ls_addr[ROW_LSB-1:0] - DLM_BASE[ROW_LSB-1:0];

   // ------------------------------
   // Data stage
   // ------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         val_md <= 1'b0;
      end else begin
         val_md <= lo_ld_acc;
      end
   end

   // Sidecars held while banks read
   always_ff @(posedge clk) begin
      if (lo_ld_acc) begin
         off_md    <= addr_lo[OFF_W-1:0];
         bsel_md   <= addr_lo[OFF_W];
         size_md   <= ls_size;
         signed_md <= ls_is_signed;
         rd_md     <= ls_res_rd;
      end
   end

   // Lanes over start word and following word
   assign span_md = {{BYTE_W{1'b0}}, size_be(size_md)} << off_md;

   // Lanes taken from bank 0
   // Start in bank 1 puts bank 0 in the high half
   assign be0_md = bsel_md ? span_md[2*BYTE_W-1:BYTE_W] : span_md[BYTE_W-1:0];

   // ------------------------------
   // Output stage
   // ------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ld_val <= 1'b0;
      end else begin
         ld_val <= val_md;
      end
   end

   always_ff @(posedge clk) begin
      if (val_md) begin
         for (int b = 0; b < `DMC_NBANKS; b++) begin
            word_out[b] <= bank_rdata[b];
         end
         be0_out      <= be0_md;
         off_out      <= off_md;
         ld_size      <= size_md;
         ld_is_signed <= signed_md;
         ld_rd        <= rd_md;
      end
   end

   // Per-lane bank merge
   always_comb begin
      for (int i = 0; i < BYTE_W; i++) begin
         merged[i*8 +: 8] = be0_out[i] ? word_out[0][i*8 +: 8] : word_out[1][i*8 +: 8];
      end
   end

   // Rotate right, first addressed byte to lane 0
   // Extension is left to the core
   always_comb begin
      for (int o = 0; o < BYTE_W; o++) begin
         int i;
         i = (o + int'(off_out)) % BYTE_W;
         ld_data[o*8 +: 8] = merged[i*8 +: 8];
      end
   end

endmodule

// File: hw/dlm_bank_mem.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module dlm_bank_mem (
   input  logic                clk,
   input  logic                cs,
   input  logic                we,
   input  dmc_pkg::bank_be_t   be,
   input  dmc_pkg::bank_addr_t row,
   input  dmc_pkg::xlen_t      wdata,
   output dmc_pkg::xlen_t      rdata
);
   import dmc_pkg::*;

   localparam int DEPTH  = 1 << `DMC_BANK_AW;
   localparam int BYTE_W = `DMC_XLEN / 8;

   // Single-port SRAM, one word per row
   xlen_t mem [0:DEPTH-1];

   // ------------------------------
   // Access port
   // ------------------------------

   always_ff @(posedge clk) begin
      if (cs) begin
         if (we) begin
            // Byte-masked write
            for (int i = 0; i < BYTE_W; i++) begin
               if (be[i]) begin
                  mem[row][i*8 +: 8] <= wdata[i*8 +: 8];
               end
            end
         end else begin
            // Registered read, valid next cycle
            rdata <= mem[row];
         end
      end
   end

endmodule

// File: hw/dlm_req_decode.sv
`timescale 1ns/1ps
`include "dmc_settings.svh"

module dlm_req_decode (
   input  logic                ls_val,
   input  logic                ls_is_ld,
   input  dmc_pkg::ls_size_e   ls_size,
   input  dmc_pkg::xlen_t      ls_addr,
   input  dmc_pkg::xlen_t      ls_wdata,
   input  logic                mst_rif_rdy,
   output logic                is_external,
   output logic                lo_ld_acc,
   output logic                bank_cs    [0:`DMC_NBANKS-1],
   output logic                bank_we    [0:`DMC_NBANKS-1],
   output dmc_pkg::bank_addr_t bank_row   [0:`DMC_NBANKS-1],
   output dmc_pkg::bank_be_t   bank_be    [0:`DMC_NBANKS-1],
   output dmc_pkg::xlen_t      bank_wdata
);
   import dmc_pkg::*;

   // Address split: | row | bank select | byte offset |
   localparam int BYTE_W  = `DMC_XLEN / 8;
   localparam int OFF_W   = $clog2(BYTE_W);
   localparam int BSEL_W  = $clog2(`DMC_NBANKS);
   localparam int ROW_LSB = OFF_W + BSEL_W;

   xlen_t               dlm_off;
   logic                is_dlm;
   logic                acc;
   logic                dlm_acc;
   logic [OFF_W-1:0]    byte_off;
   logic [BSEL_W-1:0]   bank_sel;
   logic                misaligned;
   bank_addr_t          row;
   bank_addr_t          row_next;
   logic [2*BYTE_W-1:0] span_be;

   // ------------------------------
   // Region decode
   // ------------------------------

   // Offset from DLM base, unsigned compare covers both ends
   assign dlm_off = ls_addr - xlen_t'(`DMC_DLM_BASE);

   // Only the first byte decides the target
   assign is_dlm      = dlm_off < xlen_t'(`DMC_DLM_BYTES);
   assign is_external = ~is_dlm;

   // Handshake: DLM always ready, external follows the bus
   assign acc     = ls_val & (is_dlm | mst_rif_rdy);
   assign dlm_acc = acc & is_dlm;

   // One-cycle strobe into the load pipeline
   assign lo_ld_acc = dlm_acc & ls_is_ld;

   // ------------------------------
   // Bank and row selection
   // ------------------------------

   assign byte_off = dlm_off[OFF_W-1:0];
   assign bank_sel = dlm_off[ROW_LSB-1:OFF_W];
   assign row      = dlm_off[ROW_LSB +: `DMC_BANK_AW];

   // Row after the top wraps back to row 0
   assign row_next = row + bank_addr_t'(1);

   // Lanes over two consecutive words
   // Low half is the addressed bank, high half the following one
   assign span_be = {{BYTE_W{1'b0}}, size_be(ls_size)} << byte_off;

   // Any lane in the high half means a word crossing
   assign misaligned = |span_be[2*BYTE_W-1:BYTE_W];

   always_comb begin
      for (int b = 0; b < `DMC_NBANKS; b++) begin
         bank_be_t lane_be;

         // Addressed bank, plus its neighbour on a crossing
         bank_cs[b] = dlm_acc & ((b == int'(bank_sel)) | misaligned);
         bank_we[b] = bank_cs[b] & ~ls_is_ld;

         // Bank below the start bank holds the next row
         bank_row[b] = (b < int'(bank_sel)) ? row_next : row;

         if (b == int'(bank_sel)) begin
            lane_be = span_be[BYTE_W-1:0];
         end else begin
            lane_be = span_be[2*BYTE_W-1:BYTE_W];
         end

         // Loads read full words
         bank_be[b] = bank_we[b] ? lane_be : '0;
      end
   end

   // ------------------------------
   // Store data rotation
   // ------------------------------

   // Rotate left by byte offset
   // Byte 0 of the store lands on the first addressed lane
   always_comb begin
      for (int i = 0; i < BYTE_W; i++) begin
         int o;
         o = (i + int'(byte_off)) % BYTE_W;
         bank_wdata[o*8 +: 8] = ls_wdata[i*8 +: 8];
      end
   end

endmodule

// File: hw/dmc_pkg.sv
`include "dmc_settings.svh"

package dmc_pkg;

   // ------------------------------
   // Shared types
   // ------------------------------

   // One address or data word
   typedef logic [`DMC_XLEN-1:0] xlen_t;

   // Access size, code 2'b11 is illegal
   typedef enum logic [1:0] {
      SIZE_B = 2'b00,
      SIZE_H = 2'b01,
      SIZE_W = 2'b10
   } ls_size_e;

   // Row index inside one bank
   typedef logic [`DMC_BANK_AW-1:0] bank_addr_t;

   // Byte enables of one bank word
   typedef logic [`DMC_XLEN/8-1:0] bank_be_t;

   // Destination register index
   typedef logic [`DMC_RD_W-1:0] rd_t;

   // Byte lanes touched by an access starting at lane 0
   // Illegal size touches nothing
   function automatic bank_be_t size_be(ls_size_e size);
      bank_be_t be;
      case (size)
         SIZE_B:  be = bank_be_t'(1);
         SIZE_H:  be = bank_be_t'(3);
         SIZE_W:  be = '1;
         default: be = '0;
      endcase
      return be;
   endfunction

endpackage

// File: hw/dmc_settings.svh
`ifndef DMC_SETTINGS_SVH
`define DMC_SETTINGS_SVH

// ------------------------------
// Core word
// ------------------------------

// Data and address width
`define DMC_XLEN 32

// Destination register index width
`define DMC_RD_W 5

// ------------------------------
// DLM region and banking
// ------------------------------

// First byte of the DLM region, aligned to the region size
`define DMC_DLM_BASE 32'h0001_0000

// DLM size in bytes
`define DMC_DLM_BYTES 4096

// Even/odd word striping
`define DMC_NBANKS 2

// Row index width of one bank
// 4096 bytes / 2 banks / 4 bytes per row = 512 rows
`define DMC_BANK_AW 9

`endif
